//--- hw/tdc_spi_cfg.svh
// TDC SPI master configuration: word widths, frame lengths and guard timing
`ifndef TDC_SPI_CFG_SVH
`define TDC_SPI_CFG_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define TDC_OPCODE_W  8   // Opcode byte, sent first in every frame
`define TDC_WORD_W    32  // Write word and read word
`define TDC_RD_BITS   24  // Result bits clocked in by a read

// ----------------------------------------
// Frame timing, in clk cycles
// ----------------------------------------
`define TDC_SPI_LEAD  2   // Chip select fall to first serial clock rise
`define TDC_SPI_TRAIL 2   // Last serial clock fall to chip select rise

// Guard cycles after the done cycle before the next accepting edge.
// The controller counts this through DONE and GAP, so keep it at 2 or more
`define TDC_SPI_GAP   6

`endif

//--- hw/tdc_cmd_pkg.sv
// Command-side types of the TDC SPI master: command kind, opcode, data word, controller state
`include "tdc_spi_cfg.svh"

package tdc_cmd_pkg;

	// ----------------------------------------
	// Host command
	// ----------------------------------------
	typedef enum logic [1:0] {
		CMD_WRITE = 2'd0, // Opcode plus 32-bit register word
		CMD_READ  = 2'd1, // Opcode, then 24 result bits in
		CMD_BYTE  = 2'd2  // Opcode only, init or reset
	} cmd_kind_e;

	typedef logic [`TDC_OPCODE_W-1:0] opcode_t; // Sent as an opaque byte
	typedef logic [`TDC_WORD_W-1:0]   word_t;

	// ----------------------------------------
	// Command controller FSM
	// ----------------------------------------
	typedef enum logic [1:0] {
		IDLE = 2'd0, // Waiting for a strobe
		BUSY = 2'd1, // Frame on the wire
		DONE = 2'd2, // One-cycle done pulse
		GAP  = 2'd3  // Chip recovery time
	} ctrl_state_e;

endpackage

//--- hw/spi_frame_pkg.sv
// Frame-side types of the TDC SPI master: shifter phase and bit counter
`include "tdc_spi_cfg.svh"

package spi_frame_pkg;

	typedef enum logic [1:0] {
		OFF   = 2'd0, // Chip select high, bus quiet
		LEAD  = 2'd1, // Chip select low, clock not yet running
		SHIFT = 2'd2, // Serial clock toggling
		TRAIL = 2'd3  // Clock stopped, chip select still low
	} frame_phase_e;

	// Wide enough to index every bit of the longest (write) frame
	typedef logic [$clog2(`TDC_OPCODE_W + `TDC_WORD_W + 1)-1:0] bit_cnt_t;

endpackage

//--- hw/tdc_cmd_ctrl.sv
// TDC command controller: prioritizes host strobes, acknowledges, signals done, holds the guard gap
`include "tdc_spi_cfg.svh"

module tdc_cmd_ctrl (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic                   wr_cmd_i,
	input  logic                   rd_cmd_i,
	input  logic                   byte_cmd_i,
	input  logic                   frame_end_i,
	output logic                   start_o,
	output tdc_cmd_pkg::cmd_kind_e kind_o,
	output logic                   ack_o,
	output logic                   done_o
);

	localparam int GAP_W = $clog2(`TDC_SPI_GAP);

	// Count runs from the done cycle, so the last GAP cycle is one short of the full gap
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`TDC_SPI_GAP - 1);

	tdc_cmd_pkg::ctrl_state_e state;
	logic [GAP_W-1:0]         gap_cnt;
	logic                     any_cmd;

	// ----------------------------------------
	// Strobe decode
	// ----------------------------------------
	assign any_cmd = wr_cmd_i | rd_cmd_i | byte_cmd_i;
	assign start_o = (state == tdc_cmd_pkg::IDLE) && any_cmd; // Only when idle, no queue

	always_comb begin
		if (wr_cmd_i) begin
			kind_o = tdc_cmd_pkg::CMD_WRITE; // Write wins
		end else if (rd_cmd_i) begin
			kind_o = tdc_cmd_pkg::CMD_READ;
		end else begin
			kind_o = tdc_cmd_pkg::CMD_BYTE;
		end
	end

	assign done_o = (state == tdc_cmd_pkg::DONE); // Single cycle, DONE never holds

	// ----------------------------------------
	// Acknowledge
	// ----------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= start_o; // Cycle after the accepting edge
		end
	end

	// ----------------------------------------
	// Command FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= tdc_cmd_pkg::IDLE;
			gap_cnt <= '0;
		end else begin
			case (state)
				tdc_cmd_pkg::IDLE: begin
					if (start_o) begin
						state <= tdc_cmd_pkg::BUSY;
					end
				end
				tdc_cmd_pkg::BUSY: begin
					if (frame_end_i) begin
						state   <= tdc_cmd_pkg::DONE;
						gap_cnt <= '0;
					end
				end
				tdc_cmd_pkg::DONE: begin
					state   <= tdc_cmd_pkg::GAP;
					gap_cnt <= gap_cnt + 1'b1; // Done cycle counts toward the gap
				end
				tdc_cmd_pkg::GAP: begin
					if (gap_cnt == GAP_LAST) begin
						state <= tdc_cmd_pkg::IDLE;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: begin
					state <= tdc_cmd_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/spi_frame_shifter.sv
// SPI frame shifter: chip select and serial clock timing, MSB-first transmit, read capture
`include "tdc_spi_cfg.svh"

module spi_frame_shifter (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic                   start_i,
	input  tdc_cmd_pkg::cmd_kind_e kind_i,
	input  tdc_cmd_pkg::opcode_t   opcode_i,
	input  tdc_cmd_pkg::word_t     wr_data_i,
	input  logic                   spi_so_i,
	output logic                   spi_sck_o,
	output logic                   spi_ssn_o,
	output logic                   spi_si_o,
	output tdc_cmd_pkg::word_t     rd_data_o,
	output logic                   frame_end_o
);

	localparam int TX_W  = `TDC_OPCODE_W + `TDC_WORD_W;
	localparam int TIM_W = $clog2(`TDC_SPI_LEAD + `TDC_SPI_TRAIL + 1);
	localparam int PAD_W = `TDC_WORD_W - `TDC_RD_BITS;

	localparam logic [TIM_W-1:0] LEAD_LAST  = TIM_W'(`TDC_SPI_LEAD - 1);
	localparam logic [TIM_W-1:0] TRAIL_LAST = TIM_W'(`TDC_SPI_TRAIL - 1);

	spi_frame_pkg::frame_phase_e phase;
	spi_frame_pkg::bit_cnt_t     bit_cnt;    // Index of the bit on the wire
	spi_frame_pkg::bit_cnt_t     last_bit;   // Index of the final bit of this frame
	spi_frame_pkg::bit_cnt_t     frame_last;
	logic [TIM_W-1:0]            tim_cnt;    // Lead and trail cycles
	logic                        is_rd;
	tdc_cmd_pkg::word_t          tx_word;
	logic [TX_W-1:0]             tx_sr;
	logic [`TDC_RD_BITS-1:0]     rx_sr;
	logic                        sck_rise;

	// ----------------------------------------
	// Frame setup
	// ----------------------------------------
	always_comb begin
		case (kind_i)
			tdc_cmd_pkg::CMD_WRITE: begin
				frame_last = spi_frame_pkg::bit_cnt_t'(`TDC_OPCODE_W + `TDC_WORD_W - 1);
			end
			tdc_cmd_pkg::CMD_READ: begin
				frame_last = spi_frame_pkg::bit_cnt_t'(`TDC_OPCODE_W + `TDC_RD_BITS - 1);
			end
			default: begin
				frame_last = spi_frame_pkg::bit_cnt_t'(`TDC_OPCODE_W - 1);
			end
		endcase
	end

	// Reads and single bytes keep SI low after the opcode
	assign tx_word  = (kind_i == tdc_cmd_pkg::CMD_WRITE) ? wr_data_i : '0;
	assign sck_rise = (phase == spi_frame_pkg::SHIFT) && !spi_sck_o;

	// ----------------------------------------
	// Shift registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (phase == spi_frame_pkg::OFF && start_i) begin
			tx_sr <= {opcode_i, tx_word};
		end else if (sck_rise) begin
			tx_sr <= tx_sr << 1; // Next bit to MSB
			if (is_rd && bit_cnt >= spi_frame_pkg::bit_cnt_t'(`TDC_OPCODE_W)) begin
				rx_sr <= {rx_sr[`TDC_RD_BITS-2:0], spi_so_i}; // Sample with SCK rise
			end
		end
	end

	// ----------------------------------------
	// Phase sequencer and pins
	// ----------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase       <= spi_frame_pkg::OFF;
			bit_cnt     <= '0;
			last_bit    <= '0;
			tim_cnt     <= '0;
			is_rd       <= 1'b0;
			spi_sck_o   <= 1'b0;
			spi_ssn_o   <= 1'b1;
			spi_si_o    <= 1'b0;
			frame_end_o <= 1'b0;
			rd_data_o   <= '0;
		end else begin
			frame_end_o <= 1'b0;
			case (phase)
				spi_frame_pkg::OFF: begin
					if (start_i) begin
						phase    <= spi_frame_pkg::LEAD;
						last_bit <= frame_last;
						is_rd    <= (kind_i == tdc_cmd_pkg::CMD_READ);
						bit_cnt  <= '0;
						tim_cnt  <= '0;
					end
				end
				spi_frame_pkg::LEAD: begin
					spi_ssn_o <= 1'b0; // Falls one cycle after the load
					tim_cnt   <= tim_cnt + 1'b1;
					if (tim_cnt == LEAD_LAST) begin
						phase <= spi_frame_pkg::SHIFT;
					end
				end
				spi_frame_pkg::SHIFT: begin
					spi_sck_o <= ~spi_sck_o;
					if (!spi_sck_o) begin
						spi_si_o <= tx_sr[TX_W-1]; // New bit with rising SCK
					end else if (bit_cnt == last_bit) begin
						phase   <= spi_frame_pkg::TRAIL; // Last fall
						tim_cnt <= '0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				spi_frame_pkg::TRAIL: begin
					tim_cnt <= tim_cnt + 1'b1;
					if (tim_cnt == TRAIL_LAST) begin
						spi_ssn_o   <= 1'b1;
						spi_si_o    <= 1'b0;
						frame_end_o <= 1'b1;
						phase       <= spi_frame_pkg::OFF;
					end
				end
				default: begin
					phase <= spi_frame_pkg::OFF;
				end
			endcase

			// Result lands on the done cycle, low byte zero
			if (frame_end_o && is_rd) begin
				rd_data_o <= {rx_sr, PAD_W'(0)};
			end
		end
	end

endmodule

//--- hw/tdc_spi_master.sv
// TDC SPI command master top: command controller feeding the SPI frame shifter
`include "tdc_spi_cfg.svh"

module tdc_spi_master (
	input  logic                 clk,
	input  logic                 i_rst_n,

	// Host side
	input  logic                 wr_cmd_i,
	input  logic                 rd_cmd_i,
	input  logic                 byte_cmd_i,
	input  tdc_cmd_pkg::opcode_t opcode_i,
	input  tdc_cmd_pkg::word_t   wr_data_i,
	output logic                 ack_o,
	output tdc_cmd_pkg::word_t   rd_data_o,
	output logic                 done_o,

	// Chip side
	input  logic                 spi_so_i,
	output logic                 spi_sck_o,
	output logic                 spi_ssn_o,
	output logic                 spi_si_o
);

	// ----------------------------------------
	// Controller to shifter
	// ----------------------------------------
	logic                   start;     // Accepting cycle
	tdc_cmd_pkg::cmd_kind_e kind;      // Valid with start
	logic                   frame_end; // Chip select back high

	tdc_cmd_ctrl i_tdc_cmd_ctrl (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.wr_cmd_i    (wr_cmd_i),
		.rd_cmd_i    (rd_cmd_i),
		.byte_cmd_i  (byte_cmd_i),
		.frame_end_i (frame_end),
		.start_o     (start),
		.kind_o      (kind),
		.ack_o       (ack_o),
		.done_o      (done_o)
	);

	spi_frame_shifter i_spi_frame_shifter (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.start_i     (start),
		.kind_i      (kind),
		.opcode_i    (opcode_i),   // Sampled on the accepting edge
		.wr_data_i   (wr_data_i),
		.spi_so_i    (spi_so_i),
		.spi_sck_o   (spi_sck_o),
		.spi_ssn_o   (spi_ssn_o),
		.spi_si_o    (spi_si_o),
		.rd_data_o   (rd_data_o),
		.frame_end_o (frame_end)
	);

endmodule

//--- testbench/tdc_spi_slave.sv
// Behavioral TDC chip model: records SI bits on falling SCK and drives read result bits on SO
`include "tdc_spi_cfg.svh"

module tdc_spi_slave (
	input  logic                    spi_sck_i,
	input  logic                    spi_ssn_i,
	input  logic                    spi_si_i,
	input  logic [`TDC_RD_BITS-1:0] rd_value_i, // Result returned by a read
	output logic                    spi_so_o,
	output logic [63:0]             rx_bits_o,  // Recorded SI bits, last bit in the LSB
	output spi_frame_pkg::bit_cnt_t bit_cnt_o   // Bits seen in the current frame
);
	timeunit 1ns;
	timeprecision 100ps;

	// Result bit driven after the last opcode bit, counting down to bit 0
	localparam int LAST_RD_FALL = `TDC_OPCODE_W + `TDC_RD_BITS - 1;

	int rd_idx;

	// ----------------------------------------
	// Frame capture and read data
	// ----------------------------------------
	initial begin
		spi_so_o  = 1'b0;
		rx_bits_o = '0;
		bit_cnt_o = '0;
		rd_idx    = 0;
		forever begin
			@(negedge spi_ssn_i);
			rx_bits_o = '0; // New frame
			bit_cnt_o = '0;
			spi_so_o  = 1'b0;
			while (!spi_ssn_i) begin
				@(negedge spi_sck_i or posedge spi_ssn_i);
				if (!spi_ssn_i) begin
					rx_bits_o = {rx_bits_o[62:0], spi_si_i}; // SI is stable at the fall
					bit_cnt_o = bit_cnt_o + 1'b1;
					rd_idx    = LAST_RD_FALL - int'(bit_cnt_o);

					// From the 8th fall on the chip returns its result, MSB first
					if (int'(bit_cnt_o) >= `TDC_OPCODE_W && rd_idx >= 0) begin
						spi_so_o <= rd_value_i[rd_idx];
					end else begin
						spi_so_o <= 1'b0;
					end
				end
			end
			spi_so_o <= 1'b0; // Quiet between frames
		end
	end

endmodule

//--- testbench/tdc_spi_tb.sv
// Testbench for the TDC SPI command master: directed frame, priority and guard-gap tests
`include "tdc_spi_cfg.svh"

module tdc_spi_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 8;
	localparam int GAP        = `TDC_SPI_GAP;
	localparam int ACK_LIMIT  = `TDC_SPI_GAP + 4;
	localparam int PAD_W      = `TDC_WORD_W - `TDC_RD_BITS;
	localparam int RDV_W      = `TDC_RD_BITS;
	localparam int BYTE_BITS  = `TDC_OPCODE_W;
	localparam int WR_BITS    = `TDC_OPCODE_W + `TDC_WORD_W;
	localparam int RD_BITS    = `TDC_OPCODE_W + `TDC_RD_BITS;

	// Accepting edge to done: ack cycle, lead, two cycles per bit, trail
	localparam int BYTE_LEN = 1 + `TDC_SPI_LEAD + 2 * BYTE_BITS + `TDC_SPI_TRAIL;
	localparam int WR_LEN   = 1 + `TDC_SPI_LEAD + 2 * WR_BITS + `TDC_SPI_TRAIL;
	localparam int RD_LEN   = 1 + `TDC_SPI_LEAD + 2 * RD_BITS + `TDC_SPI_TRAIL;

	// One byte, three writes and two reads, each followed by a guard gap
	localparam int RUN_CYCLES = RST_CYCLES + BYTE_LEN + 3 * WR_LEN + 2 * RD_LEN
		+ 6 * (GAP + ACK_LIMIT);
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;

	logic                    clk = 1'b0;
	logic                    i_rst_n;
	logic                    wr_cmd;
	logic                    rd_cmd;
	logic                    byte_cmd;
	tdc_cmd_pkg::opcode_t    opcode;
	tdc_cmd_pkg::word_t      wr_data;
	logic                    ack;
	tdc_cmd_pkg::word_t      rd_data;
	logic                    done;
	logic                    spi_sck;
	logic                    spi_ssn;
	logic                    spi_si;
	logic                    spi_so;
	logic [`TDC_RD_BITS-1:0] so_value;  // Chip result for the next read
	logic [63:0]             slave_bits;
	spi_frame_pkg::bit_cnt_t slave_cnt;

	integer             seed;
	int                 cyc = 0;  // Rising edges so far
	int                 ack_cyc;
	int                 done_cyc;
	tdc_cmd_pkg::word_t last_rd;   // Expected held read word

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	tdc_spi_master i_tdc_spi_master (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.wr_cmd_i   (wr_cmd),
		.rd_cmd_i   (rd_cmd),
		.byte_cmd_i (byte_cmd),
		.opcode_i   (opcode),
		.wr_data_i  (wr_data),
		.ack_o      (ack),
		.rd_data_o  (rd_data),
		.done_o     (done),
		.spi_so_i   (spi_so),
		.spi_sck_o  (spi_sck),
		.spi_ssn_o  (spi_ssn),
		.spi_si_o   (spi_si)
	);

	tdc_spi_slave i_tdc_spi_slave (
		.spi_sck_i  (spi_sck),
		.spi_ssn_i  (spi_ssn),
		.spi_si_i   (spi_si),
		.rd_value_i (so_value),
		.spi_so_o   (spi_so),
		.rx_bits_o  (slave_bits),
		.bit_cnt_o  (slave_cnt)
	);

	// ----------------------------------------
	// Checks and handshakes
	// ----------------------------------------
	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_cond(input bit cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("TEST RESULT: FAIL");
			$fatal(1, "%s", what);
		end
	endtask

	task automatic check_idle_outputs();
		check_value("spi_ssn_o", spi_ssn, 1'b1);
		check_value("spi_sck_o", spi_sck, 1'b0);
		check_value("spi_si_o", spi_si, 1'b0);
		check_value("ack_o", ack, 1'b0);
		check_value("done_o", done, 1'b0);
		check_value("rd_data_o", rd_data, '0);
	endtask

	task automatic drive_cmd(input logic wr, input logic rd, input logic bt,
			input tdc_cmd_pkg::opcode_t op, input tdc_cmd_pkg::word_t data);
		@(posedge clk);
		wr_cmd   <= wr;
		rd_cmd   <= rd;
		byte_cmd <= bt;
		opcode   <= op;
		wr_data  <= data;
	endtask

	// Holds the strobes until ack, then drops them
	task automatic wait_ack();
		int n;
		n = 0;
		@(negedge clk);
		while (!ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		check_cond(ack, "No acknowledge came for a held command strobe");
		ack_cyc = cyc;
		@(posedge clk);
		wr_cmd   <= 1'b0;
		rd_cmd   <= 1'b0;
		byte_cmd <= 1'b0;
	endtask

	task automatic wait_done(input int frame_len);
		int elapsed;
		elapsed = 0;
		while (!done) begin
			@(negedge clk);
			elapsed = cyc - ack_cyc;
			check_value("ack_o", ack, 1'b0); // One pulse only, no accept while busy
			check_cond(elapsed <= frame_len, "done_o did not rise within the frame time");
		end
		check_value("done_o latency", elapsed, frame_len);
		done_cyc = cyc;
		@(negedge clk);
		check_value("done_o", done, 1'b0);
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic test_reset();
		repeat (RST_CYCLES) begin
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		i_rst_n <= 1'b1;
		@(negedge clk);
		check_idle_outputs();
	endtask

	task automatic test_single_byte();
		tdc_cmd_pkg::opcode_t op;
		op = tdc_cmd_pkg::opcode_t'($random(seed));
		drive_cmd(1'b0, 1'b0, 1'b1, op, '0);
		wait_ack();
		wait_done(BYTE_LEN);
		check_value("slave bit count", slave_cnt, BYTE_BITS);
		check_value("recorded SI bits", slave_bits, 64'(op));
	endtask

	task automatic test_write();
		tdc_cmd_pkg::opcode_t op;
		tdc_cmd_pkg::word_t   data;
		op   = tdc_cmd_pkg::opcode_t'($random(seed));
		data = tdc_cmd_pkg::word_t'($random(seed));
		drive_cmd(1'b1, 1'b0, 1'b0, op, data);
		wait_ack();
		wait_done(WR_LEN);
		check_value("slave bit count", slave_cnt, WR_BITS);
		check_value("recorded SI bits", slave_bits, 64'({op, data}));
		check_value("rd_data_o", rd_data, last_rd); // Writes leave it alone
	endtask

	task automatic test_read();
		tdc_cmd_pkg::opcode_t op;
		op       = tdc_cmd_pkg::opcode_t'($random(seed));
		so_value = RDV_W'($random(seed));
		last_rd  = {so_value, {PAD_W{1'b0}}};
		drive_cmd(1'b0, 1'b1, 1'b0, op, tdc_cmd_pkg::word_t'($random(seed)));
		wait_ack();
		wait_done(RD_LEN);
		check_value("slave bit count", slave_cnt, RD_BITS);
		check_value("recorded SI bits", slave_bits, 64'({op, {`TDC_RD_BITS{1'b0}}}));
		check_value("rd_data_o", rd_data, last_rd);
	endtask

	task automatic test_priority();
		tdc_cmd_pkg::opcode_t op;
		tdc_cmd_pkg::word_t   data;
		op   = tdc_cmd_pkg::opcode_t'($random(seed));
		data = tdc_cmd_pkg::word_t'($random(seed));
		drive_cmd(1'b1, 1'b1, 1'b1, op, data);
		wait_ack();
		wait_done(WR_LEN);
		check_value("slave bit count", slave_cnt, WR_BITS);
		check_value("recorded SI bits", slave_bits, 64'({op, data}));
		check_value("rd_data_o", rd_data, last_rd);
	endtask

	task automatic test_busy_guard();
		tdc_cmd_pkg::opcode_t op;
		tdc_cmd_pkg::word_t   data;
		op   = tdc_cmd_pkg::opcode_t'($random(seed));
		data = tdc_cmd_pkg::word_t'($random(seed));
		drive_cmd(1'b1, 1'b0, 1'b0, op, data);
		wait_ack();
		repeat (10) @(posedge clk);
		rd_cmd <= 1'b1; // Pulse in the middle of the frame
		@(posedge clk);
		rd_cmd <= 1'b0;
		wait_done(WR_LEN);
		check_value("slave bit count", slave_cnt, WR_BITS);
		check_value("recorded SI bits", slave_bits, 64'({op, data}));

		op       = tdc_cmd_pkg::opcode_t'($random(seed));
		so_value = RDV_W'($random(seed));
		last_rd  = {so_value, {PAD_W{1'b0}}};
		@(posedge clk);
		byte_cmd <= 1'b1; // Pulse inside the guard gap
		@(posedge clk);
		byte_cmd <= 1'b0;
		rd_cmd   <= 1'b1; // Held until accepted
		opcode   <= op;

		// Accepting edge lands GAP+1 edges after the done edge
		wait_ack();
		check_value("ack_o delay after done", ack_cyc - done_cyc, GAP + 1);
		wait_done(RD_LEN);
		check_value("slave bit count", slave_cnt, RD_BITS);
		check_value("rd_data_o", rd_data, last_rd);
	endtask

	initial begin
		seed     = 32'hefced3e6;
		i_rst_n  = 1'b0;
		wr_cmd   = 1'b0;
		rd_cmd   = 1'b0;
		byte_cmd = 1'b0;
		opcode   = '0;
		wr_data  = '0;
		so_value = '0;
		last_rd  = '0;
		ack_cyc  = 0;
		done_cyc = 0;
		test_reset();
		test_single_byte();
		test_write();
		test_read();
		test_priority();
		test_busy_guard();
		$display("TEST RESULT: PASS");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- all.f
+incdir+hw
hw/tdc_cmd_pkg.sv
hw/spi_frame_pkg.sv
hw/tdc_cmd_ctrl.sv
hw/spi_frame_shifter.sv
hw/tdc_spi_master.sv
testbench/tdc_spi_slave.sv
testbench/tdc_spi_tb.sv
